//--- hdl/dcache_pkg.sv
package dcache_pkg;

    // Default cache geometry
    localparam int DEF_LINE_WIDTH = 256;
    localparam int DEF_LINE_COUNT = 16;

    // Default AXI master identity
    localparam int DEF_ID_WIDTH = 4;
    localparam int DEF_AXI_ID = 1;

    // Work the request stage hands to the bus FSM
    typedef enum logic [1:0] {
        OP_SINGLE_READ,
        OP_SINGLE_WRITE,
        OP_LINE_READ
    } bus_op_t;

    // Fixed AXI4 field encodings
    localparam logic [1:0] AXI_BURST_INCR = 2'b01;
    localparam logic [2:0] AXI_SIZE_WORD = 3'b010;

endpackage

//--- hdl/dcache_req_stage.sv
`timescale 1ns/1ps

module dcache_req_stage #(
    parameter int LINE_WIDTH = dcache_pkg::DEF_LINE_WIDTH,
    parameter int LINE_COUNT = dcache_pkg::DEF_LINE_COUNT
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                req_read,
    input  logic                req_write,
    input  logic                req_uncached,
    input  logic [31:0]         req_addr,
    input  logic [31:0]         req_wdata,
    output logic                stall,
    output logic [31:0]         rdata,
    output logic                bus_start,
    output dcache_pkg::bus_op_t bus_op,
    output logic [31:0]         bus_addr,
    output logic [31:0]         bus_wdata,
    input  logic                bus_beat_valid,
    input  logic [31:0]         bus_beat_data,
    input  logic                bus_done
);

    import dcache_pkg::*;

    localparam int WORDS = LINE_WIDTH / 32;
    localparam int OFFSET_BITS = $clog2(LINE_WIDTH / 8);
    localparam int WORD_BITS = OFFSET_BITS - 2;
    localparam int INDEX_BITS = $clog2(LINE_COUNT);
    localparam int TAG_BITS = 32 - OFFSET_BITS - INDEX_BITS;

    typedef enum logic [1:0] {
        REQ_IDLE,
        REQ_BUSY,
        REQ_DONE
    } req_state_t;

    req_state_t state;

    logic                  pipe_read;
    logic                  pipe_write;
    logic                  pipe_uncached;
    logic [31:0]           pipe_addr;
    logic [31:0]           pipe_wdata;

    logic [TAG_BITS-1:0]   pipe_tag;
    logic [INDEX_BITS-1:0] pipe_index;
    logic [WORD_BITS-1:0]  pipe_word;

    logic [LINE_COUNT-1:0] line_valid;
    logic [TAG_BITS-1:0]   line_tag [LINE_COUNT];
    logic [WORDS-1:0][31:0] line_data [LINE_COUNT];

    logic [WORD_BITS-1:0]  beat_cnt;
    logic [31:0]           rdata_q;

    logic                  fresh;
    logic                  hit;
    logic                  read_hit;
    logic                  refill;

    assign pipe_word = pipe_addr[OFFSET_BITS-1:2];
    assign pipe_index = pipe_addr[OFFSET_BITS +: INDEX_BITS];
    assign pipe_tag = pipe_addr[31 -: TAG_BITS];

    // First cycle after a request is captured
    assign fresh = (state == REQ_IDLE) && (pipe_read || pipe_write);
    assign hit = line_valid[pipe_index] && (line_tag[pipe_index] == pipe_tag);
    assign read_hit = fresh && pipe_read && !pipe_uncached && hit;

    // Anything but a cached read hit goes out on the bus
    assign bus_start = fresh && !read_hit;
    assign stall = bus_start || (state == REQ_BUSY);
    assign rdata = read_hit ? line_data[pipe_index][pipe_word] : rdata_q;

    always_comb begin
        if (!pipe_read) begin
            bus_op = OP_SINGLE_WRITE;
        end else if (pipe_uncached) begin
            bus_op = OP_SINGLE_READ;
        end else begin
            bus_op = OP_LINE_READ;
        end
    end

    // Refills start at the line boundary
    assign bus_addr = (bus_op == OP_LINE_READ) ?
                      {pipe_addr[31:OFFSET_BITS], {OFFSET_BITS{1'b0}}} : pipe_addr;
    assign bus_wdata = pipe_wdata;
    assign refill = (state == REQ_BUSY) && (bus_op == OP_LINE_READ);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pipe_read <= 1'b0;
            pipe_write <= 1'b0;
            pipe_uncached <= 1'b0;
        end else if (!stall) begin
            pipe_read <= req_read;
            pipe_write <= req_write;
            pipe_uncached <= req_uncached;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            pipe_addr <= req_addr;
            pipe_wdata <= req_wdata;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= REQ_IDLE;
        end else begin
            case (state)
                REQ_IDLE: begin
                    if (bus_start) begin
                        state <= REQ_BUSY;
                    end
                end
                REQ_BUSY: begin
                    if (bus_done) begin
                        state <= REQ_DONE;
                    end
                end
                // Stall is low here so the next request is taken
                default: begin
                    state <= REQ_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            beat_cnt <= '0;
            line_valid <= '0;
        end else if (bus_start) begin
            beat_cnt <= '0;
        end else if (refill) begin
            if (bus_beat_valid) begin
                beat_cnt <= beat_cnt + WORD_BITS'(1);
            end
            if (bus_done) begin
                line_valid[pipe_index] <= 1'b1;
            end
        end
    end

    // Line store written by store hits and by refill beats
    always_ff @(posedge clk) begin
        if (fresh && pipe_write && !pipe_uncached && hit) begin
            line_data[pipe_index][pipe_word] <= pipe_wdata;
        end
        if (refill && bus_beat_valid) begin
            line_data[pipe_index][beat_cnt] <= bus_beat_data;
        end
        if (refill && bus_done) begin
            line_tag[pipe_index] <= pipe_tag;
        end
    end

    // Keep the last read word until the next read completes
    always_ff @(posedge clk) begin
        if (read_hit) begin
            rdata_q <= line_data[pipe_index][pipe_word];
        end else if (state == REQ_BUSY && bus_beat_valid &&
                     (pipe_uncached || beat_cnt == pipe_word)) begin
            rdata_q <= bus_beat_data;
        end
    end

endmodule

//--- hdl/dcache_bus_fsm.sv
`timescale 1ns/1ps

module dcache_bus_fsm #(
    parameter int ID_WIDTH = dcache_pkg::DEF_ID_WIDTH,
    parameter int AXI_ID = dcache_pkg::DEF_AXI_ID,
    parameter int LINE_WIDTH = dcache_pkg::DEF_LINE_WIDTH
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                bus_start,
    input  dcache_pkg::bus_op_t bus_op,
    input  logic [31:0]         bus_addr,
    input  logic [31:0]         bus_wdata,
    output logic                bus_beat_valid,
    output logic [31:0]         bus_beat_data,
    output logic                bus_done,
    output logic [ID_WIDTH-1:0] axi_arid,
    output logic [31:0]         axi_araddr,
    output logic [7:0]          axi_arlen,
    output logic [$bits(dcache_pkg::AXI_SIZE_WORD)-1:0]  axi_arsize,
    output logic [$bits(dcache_pkg::AXI_BURST_INCR)-1:0] axi_arburst,
    output logic                axi_arvalid,
    input  logic                axi_arready,
    output logic [ID_WIDTH-1:0] axi_awid,
    output logic [31:0]         axi_awaddr,
    output logic [7:0]          axi_awlen,
    output logic [$bits(dcache_pkg::AXI_SIZE_WORD)-1:0]  axi_awsize,
    output logic [$bits(dcache_pkg::AXI_BURST_INCR)-1:0] axi_awburst,
    output logic                axi_awvalid,
    input  logic                axi_awready,
    output logic [31:0]         axi_wdata,
    output logic [3:0]          axi_wstrb,
    output logic                axi_wlast,
    output logic                axi_wvalid,
    input  logic                axi_wready,
    input  logic [ID_WIDTH-1:0] axi_rid,
    input  logic [31:0]         axi_rdata,
    input  logic                axi_rlast,
    input  logic                axi_rvalid,
    output logic                axi_rready,
    input  logic [ID_WIDTH-1:0] axi_bid,
    input  logic                axi_bvalid,
    output logic                axi_bready
);

    import dcache_pkg::*;

    localparam logic [7:0] LINE_LEN = 8'(LINE_WIDTH / 32 - 1);

    typedef enum logic [2:0] {
        BUS_IDLE,
        BUS_AR,
        BUS_R,
        BUS_AW,
        BUS_W,
        BUS_B
    } bus_state_t;

    bus_state_t state;
    bus_state_t state_next;

    logic [31:0] addr_q;
    logic [7:0]  len_q;
    logic [31:0] wdata_q;

    always_comb begin
        state_next = state;
        case (state)
            BUS_IDLE: begin
                if (bus_start) begin
                    state_next = (bus_op == OP_SINGLE_WRITE) ? BUS_AW : BUS_AR;
                end
            end
            BUS_AR: begin
                if (axi_arready) begin
                    state_next = BUS_R;
                end
            end
            BUS_R: begin
                if (axi_rvalid && axi_rlast) begin
                    state_next = BUS_IDLE;
                end
            end
            BUS_AW: begin
                if (axi_awready) begin
                    state_next = BUS_W;
                end
            end
            BUS_W: begin
                if (axi_wready) begin
                    state_next = BUS_B;
                end
            end
            BUS_B: begin
                if (axi_bvalid) begin
                    state_next = BUS_IDLE;
                end
            end
            default: begin
                state_next = BUS_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= BUS_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Latch the transfer so the channels stay stable under back-pressure
    always_ff @(posedge clk) begin
        if (state == BUS_IDLE && bus_start) begin
            addr_q <= bus_addr;
            len_q <= (bus_op == OP_LINE_READ) ? LINE_LEN : 8'd0;
            wdata_q <= bus_wdata;
        end
    end

    assign axi_arid = ID_WIDTH'(AXI_ID);
    assign axi_araddr = addr_q;
    assign axi_arlen = len_q;
    assign axi_arsize = AXI_SIZE_WORD;
    assign axi_arburst = AXI_BURST_INCR;
    assign axi_arvalid = (state == BUS_AR);

    assign axi_awid = ID_WIDTH'(AXI_ID);
    assign axi_awaddr = addr_q;
    assign axi_awlen = len_q;
    assign axi_awsize = AXI_SIZE_WORD;
    assign axi_awburst = AXI_BURST_INCR;
    assign axi_awvalid = (state == BUS_AW);

    // Writes are always one full word
    assign axi_wdata = wdata_q;
    assign axi_wstrb = 4'hf;
    assign axi_wlast = (state == BUS_W);
    assign axi_wvalid = (state == BUS_W);

    assign axi_rready = (state == BUS_R);
    assign axi_bready = (state == BUS_B);

    assign bus_beat_valid = (state == BUS_R) && axi_rvalid;
    assign bus_beat_data = axi_rdata;
    assign bus_done = ((state == BUS_R) && axi_rvalid && axi_rlast) ||
                      ((state == BUS_B) && axi_bvalid);

endmodule

//--- hdl/dcache_top.sv
`timescale 1ns/1ps

module dcache_top #(
    parameter int LINE_WIDTH = dcache_pkg::DEF_LINE_WIDTH,
    parameter int LINE_COUNT = dcache_pkg::DEF_LINE_COUNT,
    parameter int ID_WIDTH = dcache_pkg::DEF_ID_WIDTH,
    parameter int AXI_ID = dcache_pkg::DEF_AXI_ID
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                req_read,
    input  logic                req_write,
    input  logic                req_uncached,
    input  logic [31:0]         req_addr,
    input  logic [31:0]         req_wdata,
    output logic                stall,
    output logic [31:0]         rdata,
    output logic [ID_WIDTH-1:0] axi_arid,
    output logic [31:0]         axi_araddr,
    output logic [7:0]          axi_arlen,
    output logic [$bits(dcache_pkg::AXI_SIZE_WORD)-1:0]  axi_arsize,
    output logic [$bits(dcache_pkg::AXI_BURST_INCR)-1:0] axi_arburst,
    output logic                axi_arvalid,
    input  logic                axi_arready,
    output logic [ID_WIDTH-1:0] axi_awid,
    output logic [31:0]         axi_awaddr,
    output logic [7:0]          axi_awlen,
    output logic [$bits(dcache_pkg::AXI_SIZE_WORD)-1:0]  axi_awsize,
    output logic [$bits(dcache_pkg::AXI_BURST_INCR)-1:0] axi_awburst,
    output logic                axi_awvalid,
    input  logic                axi_awready,
    output logic [31:0]         axi_wdata,
    output logic [3:0]          axi_wstrb,
    output logic                axi_wlast,
    output logic                axi_wvalid,
    input  logic                axi_wready,
    input  logic [ID_WIDTH-1:0] axi_rid,
    input  logic [31:0]         axi_rdata,
    input  logic                axi_rlast,
    input  logic                axi_rvalid,
    output logic                axi_rready,
    input  logic [ID_WIDTH-1:0] axi_bid,
    input  logic                axi_bvalid,
    output logic                axi_bready
);

    import dcache_pkg::*;

    logic        bus_start;
    bus_op_t     bus_op;
    logic [31:0] bus_addr;
    logic [31:0] bus_wdata;
    logic        bus_beat_valid;
    logic [31:0] bus_beat_data;
    logic        bus_done;

    dcache_req_stage #(
        .LINE_WIDTH(LINE_WIDTH),
        .LINE_COUNT(LINE_COUNT)
    ) req_stage_i (
        .clk(clk),
        .rst(rst),
        .req_read(req_read),
        .req_write(req_write),
        .req_uncached(req_uncached),
        .req_addr(req_addr),
        .req_wdata(req_wdata),
        .stall(stall),
        .rdata(rdata),
        .bus_start(bus_start),
        .bus_op(bus_op),
        .bus_addr(bus_addr),
        .bus_wdata(bus_wdata),
        .bus_beat_valid(bus_beat_valid),
        .bus_beat_data(bus_beat_data),
        .bus_done(bus_done)
    );

    dcache_bus_fsm #(
        .ID_WIDTH(ID_WIDTH),
        .AXI_ID(AXI_ID),
        .LINE_WIDTH(LINE_WIDTH)
    ) bus_fsm_i (
        .clk(clk),
        .rst(rst),
        .bus_start(bus_start),
        .bus_op(bus_op),
        .bus_addr(bus_addr),
        .bus_wdata(bus_wdata),
        .bus_beat_valid(bus_beat_valid),
        .bus_beat_data(bus_beat_data),
        .bus_done(bus_done),
        .axi_arid(axi_arid),
        .axi_araddr(axi_araddr),
        .axi_arlen(axi_arlen),
        .axi_arsize(axi_arsize),
        .axi_arburst(axi_arburst),
        .axi_arvalid(axi_arvalid),
        .axi_arready(axi_arready),
        .axi_awid(axi_awid),
        .axi_awaddr(axi_awaddr),
        .axi_awlen(axi_awlen),
        .axi_awsize(axi_awsize),
        .axi_awburst(axi_awburst),
        .axi_awvalid(axi_awvalid),
        .axi_awready(axi_awready),
        .axi_wdata(axi_wdata),
        .axi_wstrb(axi_wstrb),
        .axi_wlast(axi_wlast),
        .axi_wvalid(axi_wvalid),
        .axi_wready(axi_wready),
        .axi_rid(axi_rid),
        .axi_rdata(axi_rdata),
        .axi_rlast(axi_rlast),
        .axi_rvalid(axi_rvalid),
        .axi_rready(axi_rready),
        .axi_bid(axi_bid),
        .axi_bvalid(axi_bvalid),
        .axi_bready(axi_bready)
    );

endmodule

//--- tb/axi_mem_model.sv
`timescale 1ns/1ps

module axi_mem_model #(
    parameter int          ID_WIDTH = 4,
    parameter logic [31:0] SEED = 32'd2741
) (
    input  logic                clk,
    input  logic                rst,
    input  logic [ID_WIDTH-1:0] axi_arid,
    input  logic [31:0]         axi_araddr,
    input  logic [7:0]          axi_arlen,
    input  logic                axi_arvalid,
    output logic                axi_arready,
    input  logic [ID_WIDTH-1:0] axi_awid,
    input  logic [31:0]         axi_awaddr,
    input  logic                axi_awvalid,
    output logic                axi_awready,
    input  logic [31:0]         axi_wdata,
    output logic                axi_wready,
    output logic [ID_WIDTH-1:0] axi_rid,
    output logic [31:0]         axi_rdata,
    output logic                axi_rlast,
    output logic                axi_rvalid,
    output logic [ID_WIDTH-1:0] axi_bid,
    output logic                axi_bvalid
);

    logic [31:0] mem [1024];
    logic [31:0] rng;

    // Every word of the preload depends on its full index
    function automatic logic [31:0] fill_word(input logic [9:0] widx);
        return (32'(widx) * 32'h0101_0193) ^ 32'h5a5a_0000;
    endfunction

    // Stretch a phase by 0 to 3 cycles
    task automatic random_wait();
        rng = rng * 32'd1103515245 + 32'd12345;
        repeat (rng[17:16]) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic serve_read();
        logic [9:0] base;
        logic [7:0] len;
        int         b;
        random_wait();
        base = axi_araddr[11:2];
        len = axi_arlen;
        axi_rid = axi_arid;
        axi_arready = 1'b1;
        @(posedge clk);
        #1;
        axi_arready = 1'b0;
        for (b = 0; b <= int'(len); b++) begin
            random_wait();
            axi_rdata = mem[base + 10'(b)];
            axi_rlast = (b == int'(len));
            axi_rvalid = 1'b1;
            @(posedge clk);
            #1;
            axi_rvalid = 1'b0;
            axi_rlast = 1'b0;
        end
    endtask

    task automatic serve_write();
        logic [9:0] widx;
        random_wait();
        widx = axi_awaddr[11:2];
        axi_bid = axi_awid;
        axi_awready = 1'b1;
        @(posedge clk);
        #1;
        axi_awready = 1'b0;
        random_wait();
        mem[widx] = axi_wdata;
        axi_wready = 1'b1;
        @(posedge clk);
        #1;
        axi_wready = 1'b0;
        random_wait();
        axi_bvalid = 1'b1;
        @(posedge clk);
        #1;
        axi_bvalid = 1'b0;
    endtask

    initial begin
        int i;
        rng = SEED;
        axi_arready = 1'b0;
        axi_awready = 1'b0;
        axi_wready = 1'b0;
        axi_rid = '0;
        axi_rdata = '0;
        axi_rlast = 1'b0;
        axi_rvalid = 1'b0;
        axi_bid = '0;
        axi_bvalid = 1'b0;
        for (i = 0; i < 1024; i++) begin
            mem[i] = fill_word(10'(i));
        end
        // The master never overlaps transactions
        forever begin
            @(posedge clk);
            #1;
            if (!rst && axi_arvalid) begin
                serve_read();
            end else if (!rst && axi_awvalid) begin
                serve_write();
            end
        end
    end

endmodule

//--- tb/tb_dcache.sv
`timescale 1ns/1ps

module tb_dcache;

    import dcache_pkg::*;

    localparam int WORDS = DEF_LINE_WIDTH / 32;
    localparam int LINES = DEF_LINE_COUNT;
    localparam int TIMEOUT = 200;

    logic                    clk;
    logic                    rst;
    logic                    req_read;
    logic                    req_write;
    logic                    req_uncached;
    logic [31:0]             req_addr;
    logic [31:0]             req_wdata;
    logic                    stall;
    logic [31:0]             rdata;
    logic [DEF_ID_WIDTH-1:0] axi_arid;
    logic [31:0]             axi_araddr;
    logic [7:0]              axi_arlen;
    logic [2:0]              axi_arsize;
    logic [1:0]              axi_arburst;
    logic                    axi_arvalid;
    logic                    axi_arready;
    logic [DEF_ID_WIDTH-1:0] axi_awid;
    logic [31:0]             axi_awaddr;
    logic [7:0]              axi_awlen;
    logic [2:0]              axi_awsize;
    logic [1:0]              axi_awburst;
    logic                    axi_awvalid;
    logic                    axi_awready;
    logic [31:0]             axi_wdata;
    logic [3:0]              axi_wstrb;
    logic                    axi_wlast;
    logic                    axi_wvalid;
    logic                    axi_wready;
    logic [DEF_ID_WIDTH-1:0] axi_rid;
    logic [31:0]             axi_rdata;
    logic                    axi_rlast;
    logic                    axi_rvalid;
    logic                    axi_rready;
    logic [DEF_ID_WIDTH-1:0] axi_bid;
    logic                    axi_bvalid;
    logic                    axi_bready;

    // Reference memory and cache
    logic [31:0]      ref_mem [1024];
    logic [LINES-1:0] ref_valid;
    logic [22:0]      ref_tag [LINES];
    logic [31:0]      ref_line [LINES][WORDS];

    logic [31:0] rng;
    logic [31:0] last_araddr;
    logic [7:0]  last_arlen;
    logic [31:0] last_awaddr;
    logic [7:0]  last_awlen;
    logic [31:0] last_wdata;
    logic        timed_out = 1'b0;
    int          errors = 0;
    int          checks = 0;
    int          ar_count = 0;
    int          aw_count = 0;
    int          w_count = 0;
    int          r_count = 0;
    int          ar_mark;
    int          aw_mark;
    int          w_mark;
    int          r_mark;

    dcache_top dut_i (.*);

    axi_mem_model #(
        .ID_WIDTH(DEF_ID_WIDTH),
        .SEED(32'd2741)
    ) mem_i (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    function automatic logic [31:0] fill_word(input logic [9:0] widx);
        return (32'(widx) * 32'h0101_0193) ^ 32'h5a5a_0000;
    endfunction

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    // Bus monitor
    always @(negedge clk) begin
        if (axi_arvalid && axi_arready) begin
            ar_count++;
            last_araddr = axi_araddr;
            last_arlen = axi_arlen;
            // 4-byte beats in INCR bursts
            check_value("axi_arid", 32'(axi_arid), 32'(DEF_AXI_ID));
            check_value("axi_arsize", 32'(axi_arsize), 32'd2);
            check_value("axi_arburst", 32'(axi_arburst), 32'd1);
        end
        if (axi_awvalid && axi_awready) begin
            aw_count++;
            last_awaddr = axi_awaddr;
            last_awlen = axi_awlen;
            check_value("axi_awid", 32'(axi_awid), 32'(DEF_AXI_ID));
            check_value("axi_awsize", 32'(axi_awsize), 32'd2);
            check_value("axi_awburst", 32'(axi_awburst), 32'd1);
        end
        if (axi_wvalid && axi_wready) begin
            w_count++;
            last_wdata = axi_wdata;
            check_value("axi_wlast", 32'(axi_wlast), 32'd1);
            check_value("axi_wstrb", 32'(axi_wstrb), 32'hf);
        end
        if (axi_rvalid && axi_rready) begin
            r_count++;
        end
    end

    task automatic mark_bus();
        ar_mark = ar_count;
        aw_mark = aw_count;
        w_mark = w_count;
        r_mark = r_count;
    endtask

    task automatic expect_bus(input int ar, input int aw, input int beats);
        check_value("AR handshakes", 32'(ar_count - ar_mark), 32'(ar));
        check_value("AW handshakes", 32'(aw_count - aw_mark), 32'(aw));
        check_value("W handshakes", 32'(w_count - w_mark), 32'(aw));
        check_value("R beats", 32'(r_count - r_mark), 32'(beats));
    endtask

    task automatic model_access(input logic rd, input logic unc, input logic [31:0] addr,
                                input logic [31:0] wdata, output logic [31:0] exp);
        logic [9:0]  widx;
        logic [3:0]  idx;
        logic [2:0]  word;
        logic [22:0] tag;
        logic        hit;
        int          w;
        widx = addr[11:2];
        idx = addr[8:5];
        word = addr[4:2];
        tag = addr[31:9];
        hit = ref_valid[idx] && (ref_tag[idx] == tag);
        exp = '0;
        if (rd && unc) begin
            exp = ref_mem[widx];
        end else if (rd) begin
            if (!hit) begin
                for (w = 0; w < WORDS; w++) begin
                    ref_line[idx][w] = ref_mem[{widx[9:3], 3'(w)}];
                end
                ref_valid[idx] = 1'b1;
                ref_tag[idx] = tag;
            end
            exp = ref_line[idx][word];
        end else begin
            // Stores never allocate and uncached ones leave the line stale
            ref_mem[widx] = wdata;
            if (!unc && hit) begin
                ref_line[idx][word] = wdata;
            end
        end
    endtask

    task automatic access(input logic rd, input logic unc, input logic [31:0] addr,
                          input logic [31:0] wdata, output logic [31:0] got,
                          output logic stalled);
        logic [31:0] exp;
        int          cycles;
        got = '0;
        stalled = 1'b0;
        if (!timed_out) begin
            req_read = rd;
            req_write = !rd;
            req_uncached = unc;
            req_addr = addr;
            req_wdata = wdata;
            @(posedge clk);
            #1;
            req_read = 1'b0;
            req_write = 1'b0;
            stalled = stall;
            cycles = 0;
            while (stall && cycles < TIMEOUT) begin
                @(posedge clk);
                #1;
                cycles++;
            end
            assert (!stall) else begin
                errors++;
                timed_out = 1'b1;
                $display("timeout: stall stayed high for %0d cycles after request to %h",
                         TIMEOUT, addr);
            end
            got = rdata;
            model_access(rd, unc, addr, wdata, exp);
            if (rd && !timed_out) begin
                check_value("rdata", got, exp);
            end
            if (!rd && !timed_out) begin
                check_value("axi_awaddr", last_awaddr, addr);
                check_value("axi_wdata", last_wdata, wdata);
            end
        end
    endtask

    initial begin
        int          i;
        logic [31:0] addr;
        logic [31:0] got;
        logic        stalled;
        logic        rd;
        logic        unc;
        rst = 1'b1;
        req_read = 1'b0;
        req_write = 1'b0;
        req_uncached = 1'b0;
        req_addr = '0;
        req_wdata = '0;
        rng = 32'd3180;
        ref_valid = '0;
        for (i = 0; i < 1024; i++) begin
            ref_mem[i] = fill_word(10'(i));
        end
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        @(posedge clk);
        #1;
        check_value("stall", 32'(stall), 32'd0);
        check_value("axi_arvalid", 32'(axi_arvalid), 32'd0);
        check_value("axi_awvalid", 32'(axi_awvalid), 32'd0);
        check_value("axi_wvalid", 32'(axi_wvalid), 32'd0);
        check_value("axi_rready", 32'(axi_rready), 32'd0);
        check_value("axi_bready", 32'(axi_bready), 32'd0);

        // Uncached round trip with single beats
        mark_bus();
        access(1'b0, 1'b1, 32'h0000_0404, 32'hcafe_0001, got, stalled);
        expect_bus(0, 1, 0);
        check_value("axi_awlen", 32'(last_awlen), 32'd0);
        check_value("axi_wdata", last_wdata, 32'hcafe_0001);
        mark_bus();
        access(1'b1, 1'b1, 32'h0000_0404, 32'h0, got, stalled);
        expect_bus(1, 0, 1);
        check_value("axi_araddr", last_araddr, 32'h0000_0404);
        check_value("axi_arlen", 32'(last_arlen), 32'd0);

        // Refill then a hit in the same line
        mark_bus();
        access(1'b1, 1'b0, 32'h0000_0868, 32'h0, got, stalled);
        expect_bus(1, 0, WORDS);
        check_value("axi_araddr", last_araddr, 32'h0000_0860);
        check_value("axi_arlen", 32'(last_arlen), 32'(WORDS - 1));
        mark_bus();
        access(1'b1, 1'b0, 32'h0000_0874, 32'h0, got, stalled);
        expect_bus(0, 0, 0);
        check_value("stall", 32'(stalled), 32'd0);

        // Write-through on a hit and on a miss
        mark_bus();
        access(1'b0, 1'b0, 32'h0000_0870, 32'h1234_abcd, got, stalled);
        expect_bus(0, 1, 0);
        check_value("axi_wdata", last_wdata, 32'h1234_abcd);
        access(1'b1, 1'b0, 32'h0000_0870, 32'h0, got, stalled);
        check_value("stall", 32'(stalled), 32'd0);
        mark_bus();
        access(1'b0, 1'b0, 32'h0000_08a4, 32'h0bad_f00d, got, stalled);
        expect_bus(0, 1, 0);
        mark_bus();
        access(1'b1, 1'b0, 32'h0000_08a4, 32'h0, got, stalled);
        expect_bus(1, 0, WORDS);
        check_value("rdata", got, 32'h0bad_f00d);

        // Uncached store behind a cached line
        access(1'b0, 1'b1, 32'h0000_0868, 32'h5555_aaaa, got, stalled);
        access(1'b1, 1'b0, 32'h0000_0868, 32'h0, got, stalled);
        check_value("rdata", got, fill_word(10'h21a));

        for (i = 0; i < 2000 && !timed_out; i++) begin
            rng = lcg_next(rng);
            rd = (rng[31:29] < 3'd5);
            unc = (rng[28:27] == 2'd0);
            // Four indexes under two tags to force hits and evictions
            addr = {22'd0, rng[26], 2'd0, rng[25:24], rng[23:21], 2'd0};
            rng = lcg_next(rng);
            access(rd, unc, addr, rng, got, stalled);
        end

        $display("checks: %0d errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- build.f
hdl/dcache_pkg.sv
hdl/dcache_req_stage.sv
hdl/dcache_bus_fsm.sv
hdl/dcache_top.sv
tb/axi_mem_model.sv
tb/tb_dcache.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_dcache
FILELIST  = build.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
SOURCES   = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
